// File: Makefile
SIM       := verilator
SIM_FLAGS := --binary --timing --assert
TOP       := ao_peripheral_subsystem_tb
FILE_LIST := build.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(OBJ_DIR)

# Pass or fail is taken from the log
run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^SIMULATION PASSED$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: build.f
hdl/ao_periph_pkg.sv
hdl/bus_to_reg_bridge.sv
hdl/ao_reg_demux.sv
hdl/soc_ctrl.sv
hdl/gpio_ao.sv
hdl/fast_intr_ctrl.sv
hdl/ao_peripheral_subsystem.sv
tests/ao_peripheral_subsystem_assertions.sv
tests/ao_peripheral_subsystem_tb.sv

// File: hdl/ao_periph_pkg.sv
/* Shared types, always-on address map, unmapped read pattern
   and the byte-enable mask helper */
`default_nettype none

package ao_periph_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0]  strb_t;
  typedef logic [11:0] reg_offset_t;

  typedef enum logic [1:0] {
    SEL_SOC_CTRL,
    SEL_GPIO,
    SEL_FAST_INTR,
    SEL_NONE
  } periph_sel_e;

  // Bits 31:16 of an always-on address match this base
  localparam addr_t AO_BASE_ADDR = 32'h2000_0000;

  // 4 KiB window starts picked by bits 15:12
  localparam logic [15:0] SOC_CTRL_OFFSET  = 16'h0000;
  localparam logic [15:0] GPIO_OFFSET      = 16'h1000;
  localparam logic [15:0] FAST_INTR_OFFSET = 16'h2000;

  localparam data_t ERR_RDATA = 32'hBADC_AB1E;

  // Expand byte enables into a bit mask
  function automatic data_t be_to_mask(strb_t be);
    data_t mask;
    for (int i = 0; i < 4; i++) begin
      mask[8*i +: 8] = {8{be[i]}};
    end
    return mask;
  endfunction

endpackage

`default_nettype wire

// File: hdl/ao_peripheral_subsystem.sv
/* Always-on peripheral block with the bridge, the decoder,
   SoC control, GPIO and the fast interrupt controller */
`default_nettype none

module ao_peripheral_subsystem #(
  parameter int unsigned NUM_GPIO      = 8,
  parameter int unsigned NUM_FAST_INTR = 15
) (
  input  logic                     clk_i,
  input  logic                     rst_i,

  input  logic                     bus_req_i,
  input  ao_periph_pkg::addr_t     bus_addr_i,
  input  logic                     bus_we_i,
  input  ao_periph_pkg::strb_t     bus_be_i,
  input  ao_periph_pkg::data_t     bus_wdata_i,
  output logic                     bus_gnt_o,
  output logic                     bus_rvalid_o,
  output ao_periph_pkg::data_t     bus_rdata_o,

  input  logic                     boot_select_i,
  input  logic                     execute_from_flash_i,
  output logic                     exit_valid_o,
  output ao_periph_pkg::data_t     exit_value_o,

  input  logic [NUM_GPIO-1:0]      cio_gpio_i,
  output logic [NUM_GPIO-1:0]      cio_gpio_o,
  output logic [NUM_GPIO-1:0]      cio_gpio_en_o,
  output logic [NUM_GPIO-1:0]      intr_gpio_o,

  input  logic [NUM_FAST_INTR-1:0] fast_intr_i,
  output logic [NUM_FAST_INTR-1:0] fast_intr_o
);

  import ao_periph_pkg::*;

  logic        reg_valid;
  logic        reg_write;
  addr_t       reg_addr;
  strb_t       reg_be;
  data_t       reg_wdata;
  data_t       reg_rdata;
  reg_offset_t reg_offset;

  logic  soc_ctrl_valid;
  logic  gpio_valid;
  logic  fast_intr_valid;
  data_t soc_ctrl_rdata;
  data_t gpio_rdata;
  data_t fast_intr_rdata;

  bus_to_reg_bridge u_bus_to_reg_bridge (
    .clk_i,
    .rst_i,
    .bus_req_i,
    .bus_addr_i,
    .bus_we_i,
    .bus_be_i,
    .bus_wdata_i,
    .bus_gnt_o,
    .bus_rvalid_o,
    .bus_rdata_o,
    .reg_valid_o (reg_valid),
    .reg_write_o (reg_write),
    .reg_addr_o  (reg_addr),
    .reg_be_o    (reg_be),
    .reg_wdata_o (reg_wdata),
    .reg_rdata_i (reg_rdata)
  );

  ao_reg_demux u_ao_reg_demux (
    .reg_valid_i       (reg_valid),
    .reg_addr_i        (reg_addr),
    .soc_ctrl_valid_o  (soc_ctrl_valid),
    .gpio_valid_o      (gpio_valid),
    .fast_intr_valid_o (fast_intr_valid),
    .offset_o          (reg_offset),
    .soc_ctrl_rdata_i  (soc_ctrl_rdata),
    .gpio_rdata_i      (gpio_rdata),
    .fast_intr_rdata_i (fast_intr_rdata),
    .reg_rdata_o       (reg_rdata)
  );

  soc_ctrl u_soc_ctrl (
    .clk_i,
    .rst_i,
    .valid_i  (soc_ctrl_valid),
    .write_i  (reg_write),
    .offset_i (reg_offset),
    .be_i     (reg_be),
    .wdata_i  (reg_wdata),
    .rdata_o  (soc_ctrl_rdata),
    .boot_select_i,
    .execute_from_flash_i,
    .exit_valid_o,
    .exit_value_o
  );

  gpio_ao #(
    .NUM_GPIO (NUM_GPIO)
  ) u_gpio_ao (
    .clk_i,
    .rst_i,
    .valid_i  (gpio_valid),
    .write_i  (reg_write),
    .offset_i (reg_offset),
    .be_i     (reg_be),
    .wdata_i  (reg_wdata),
    .rdata_o  (gpio_rdata),
    .cio_gpio_i,
    .cio_gpio_o,
    .cio_gpio_en_o,
    .intr_gpio_o
  );

  fast_intr_ctrl #(
    .NUM_FAST_INTR (NUM_FAST_INTR)
  ) u_fast_intr_ctrl (
    .clk_i,
    .rst_i,
    .valid_i  (fast_intr_valid),
    .write_i  (reg_write),
    .offset_i (reg_offset),
    .be_i     (reg_be),
    .wdata_i  (reg_wdata),
    .rdata_o  (fast_intr_rdata),
    .fast_intr_i,
    .fast_intr_o
  );

endmodule

`default_nettype wire

// File: hdl/ao_reg_demux.sv
/* Address decode and strobe / read data steering
   for the always-on peripherals */
`default_nettype none

module ao_reg_demux (
  input  logic                       reg_valid_i,
  input  ao_periph_pkg::addr_t       reg_addr_i,

  output logic                       soc_ctrl_valid_o,
  output logic                       gpio_valid_o,
  output logic                       fast_intr_valid_o,
  output ao_periph_pkg::reg_offset_t offset_o,

  input  ao_periph_pkg::data_t       soc_ctrl_rdata_i,
  input  ao_periph_pkg::data_t       gpio_rdata_i,
  input  ao_periph_pkg::data_t       fast_intr_rdata_i,
  output ao_periph_pkg::data_t       reg_rdata_o
);

  import ao_periph_pkg::*;

  periph_sel_e sel;

  always_comb begin
    sel = SEL_NONE;
    if (reg_addr_i[31:16] == AO_BASE_ADDR[31:16]) begin
      case (reg_addr_i[15:12])
        SOC_CTRL_OFFSET[15:12]:  sel = SEL_SOC_CTRL;
        GPIO_OFFSET[15:12]:      sel = SEL_GPIO;
        FAST_INTR_OFFSET[15:12]: sel = SEL_FAST_INTR;
        default:                 sel = SEL_NONE;
      endcase
    end
  end

  // At most one strobe and none for an unmapped address
  assign soc_ctrl_valid_o  = reg_valid_i && (sel == SEL_SOC_CTRL);
  assign gpio_valid_o      = reg_valid_i && (sel == SEL_GPIO);
  assign fast_intr_valid_o = reg_valid_i && (sel == SEL_FAST_INTR);

  assign offset_o = reg_addr_i[11:0];

  always_comb begin
    case (sel)
      SEL_SOC_CTRL:  reg_rdata_o = soc_ctrl_rdata_i;
      SEL_GPIO:      reg_rdata_o = gpio_rdata_i;
      SEL_FAST_INTR: reg_rdata_o = fast_intr_rdata_i;
      default:       reg_rdata_o = ERR_RDATA;
    endcase
  end

endmodule

`default_nettype wire

// File: hdl/bus_to_reg_bridge.sv
/* Bus to register bridge with a single transfer in flight */
`default_nettype none

module bus_to_reg_bridge (
  input  logic                 clk_i,
  input  logic                 rst_i,

  input  logic                 bus_req_i,
  input  ao_periph_pkg::addr_t bus_addr_i,
  input  logic                 bus_we_i,
  input  ao_periph_pkg::strb_t bus_be_i,
  input  ao_periph_pkg::data_t bus_wdata_i,
  output logic                 bus_gnt_o,
  output logic                 bus_rvalid_o,
  output ao_periph_pkg::data_t bus_rdata_o,

  output logic                 reg_valid_o,
  output logic                 reg_write_o,
  output ao_periph_pkg::addr_t reg_addr_o,
  output ao_periph_pkg::strb_t reg_be_o,
  output ao_periph_pkg::data_t reg_wdata_o,
  input  ao_periph_pkg::data_t reg_rdata_i
);

  import ao_periph_pkg::*;

  logic  access_q;
  logic  response_q;
  logic  we_q;
  addr_t addr_q;
  strb_t be_q;
  data_t wdata_q;
  data_t rdata_q;

  // Grant only when nothing is outstanding
  assign bus_gnt_o = bus_req_i & ~access_q & ~response_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      access_q   <= 1'b0;
      response_q <= 1'b0;
    end else begin
      access_q   <= bus_gnt_o;
      response_q <= access_q;
    end
  end

  always_ff @(posedge clk_i) begin
    if (bus_gnt_o) begin
      we_q    <= bus_we_i;
      addr_q  <= bus_addr_i;
      be_q    <= bus_be_i;
      wdata_q <= bus_wdata_i;
    end
    // Writes return zero
    if (access_q) begin
      rdata_q <= we_q ? '0 : reg_rdata_i;
    end
  end

  assign reg_valid_o  = access_q;
  assign reg_write_o  = we_q;
  assign reg_addr_o   = addr_q;
  assign reg_be_o     = be_q;
  assign reg_wdata_o  = wdata_q;
  assign bus_rvalid_o = response_q;
  assign bus_rdata_o  = rdata_q;

endmodule

`default_nettype wire

// File: hdl/fast_intr_ctrl.sv
/* Fast interrupt controller with sticky pending bits and an enable mask */
`default_nettype none

module fast_intr_ctrl #(
  parameter int unsigned NUM_FAST_INTR = 15
) (
  input  logic                       clk_i,
  input  logic                       rst_i,

  input  logic                       valid_i,
  input  logic                       write_i,
  input  ao_periph_pkg::reg_offset_t offset_i,
  input  ao_periph_pkg::strb_t       be_i,
  input  ao_periph_pkg::data_t       wdata_i,
  output ao_periph_pkg::data_t       rdata_o,

  input  logic [NUM_FAST_INTR-1:0]   fast_intr_i,
  output logic [NUM_FAST_INTR-1:0]   fast_intr_o
);

  import ao_periph_pkg::*;

  localparam reg_offset_t PENDING_OFFSET = 12'h000;
  localparam reg_offset_t ENABLE_OFFSET  = 12'h004;

  logic                     wr_en;
  data_t                    wmask;
  logic [NUM_FAST_INTR-1:0] wmask_f;
  logic [NUM_FAST_INTR-1:0] wdata_f;
  logic [NUM_FAST_INTR-1:0] pending_clr;
  logic [NUM_FAST_INTR-1:0] pending_q;
  logic [NUM_FAST_INTR-1:0] enable_q;

  assign wr_en   = valid_i & write_i;
  assign wmask   = be_to_mask(be_i);
  assign wmask_f = wmask[NUM_FAST_INTR-1:0];
  assign wdata_f = wdata_i[NUM_FAST_INTR-1:0];

  assign pending_clr = (wr_en && offset_i == PENDING_OFFSET) ? (wdata_f & wmask_f) : '0;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      pending_q <= '0;
      enable_q  <= '0;
    end else begin
      // A high input sets even against a clear
      pending_q <= (pending_q & ~pending_clr) | fast_intr_i;
      if (wr_en && offset_i == ENABLE_OFFSET) begin
        enable_q <= (enable_q & ~wmask_f) | (wdata_f & wmask_f);
      end
    end
  end

  always_comb begin
    rdata_o = '0;
    case (offset_i)
      PENDING_OFFSET: rdata_o[NUM_FAST_INTR-1:0] = pending_q;
      ENABLE_OFFSET:  rdata_o[NUM_FAST_INTR-1:0] = enable_q;
      default:        rdata_o = '0;
    endcase
  end

  assign fast_intr_o = pending_q & enable_q;

endmodule

`default_nettype wire

// File: hdl/gpio_ao.sv
/* Always-on GPIO with output and enable registers, an input synchronizer
   and rising-edge interrupt status that is cleared by writing 1 */
`default_nettype none

module gpio_ao #(
  parameter int unsigned NUM_GPIO = 8
) (
  input  logic                       clk_i,
  input  logic                       rst_i,

  input  logic                       valid_i,
  input  logic                       write_i,
  input  ao_periph_pkg::reg_offset_t offset_i,
  input  ao_periph_pkg::strb_t       be_i,
  input  ao_periph_pkg::data_t       wdata_i,
  output ao_periph_pkg::data_t       rdata_o,

  input  logic [NUM_GPIO-1:0]        cio_gpio_i,
  output logic [NUM_GPIO-1:0]        cio_gpio_o,
  output logic [NUM_GPIO-1:0]        cio_gpio_en_o,
  output logic [NUM_GPIO-1:0]        intr_gpio_o
);

  import ao_periph_pkg::*;

  localparam reg_offset_t GPIO_IN_OFFSET          = 12'h000;
  localparam reg_offset_t GPIO_OUT_OFFSET         = 12'h004;
  localparam reg_offset_t GPIO_OUT_EN_OFFSET      = 12'h008;
  localparam reg_offset_t GPIO_INTR_EN_OFFSET     = 12'h00C;
  localparam reg_offset_t GPIO_INTR_STATUS_OFFSET = 12'h010;

  logic                wr_en;
  data_t               wmask;
  logic [NUM_GPIO-1:0] wmask_g;
  logic [NUM_GPIO-1:0] wdata_g;
  logic [NUM_GPIO-1:0] sync_q1;
  logic [NUM_GPIO-1:0] sync_q2;
  logic [NUM_GPIO-1:0] sync_prev_q;
  logic [NUM_GPIO-1:0] rise;
  logic [NUM_GPIO-1:0] status_clr;
  logic [NUM_GPIO-1:0] out_q;
  logic [NUM_GPIO-1:0] out_en_q;
  logic [NUM_GPIO-1:0] intr_en_q;
  logic [NUM_GPIO-1:0] intr_status_q;

  assign wr_en   = valid_i & write_i;
  assign wmask   = be_to_mask(be_i);
  assign wmask_g = wmask[NUM_GPIO-1:0];
  assign wdata_g = wdata_i[NUM_GPIO-1:0];

  assign rise       = sync_q2 & ~sync_prev_q;
  assign status_clr = (wr_en && offset_i == GPIO_INTR_STATUS_OFFSET) ?
                      (wdata_g & wmask_g) : '0;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      sync_q1       <= '0;
      sync_q2       <= '0;
      sync_prev_q   <= '0;
      out_q         <= '0;
      out_en_q      <= '0;
      intr_en_q     <= '0;
      intr_status_q <= '0;
    end else begin
      // Two-flop synchronizer plus edge history
      sync_q1     <= cio_gpio_i;
      sync_q2     <= sync_q1;
      sync_prev_q <= sync_q2;
      // New edge wins over a clear
      intr_status_q <= (intr_status_q & ~status_clr) | rise;
      if (wr_en) begin
        case (offset_i)
          GPIO_OUT_OFFSET:     out_q <= (out_q & ~wmask_g) | (wdata_g & wmask_g);
          GPIO_OUT_EN_OFFSET:  out_en_q <= (out_en_q & ~wmask_g) | (wdata_g & wmask_g);
          GPIO_INTR_EN_OFFSET: intr_en_q <= (intr_en_q & ~wmask_g) | (wdata_g & wmask_g);
          default: ;
        endcase
      end
    end
  end

  always_comb begin
    rdata_o = '0;
    case (offset_i)
      GPIO_IN_OFFSET:          rdata_o[NUM_GPIO-1:0] = sync_q2;
      GPIO_OUT_OFFSET:         rdata_o[NUM_GPIO-1:0] = out_q;
      GPIO_OUT_EN_OFFSET:      rdata_o[NUM_GPIO-1:0] = out_en_q;
      GPIO_INTR_EN_OFFSET:     rdata_o[NUM_GPIO-1:0] = intr_en_q;
      GPIO_INTR_STATUS_OFFSET: rdata_o[NUM_GPIO-1:0] = intr_status_q;
      default:                 rdata_o = '0;
    endcase
  end

  assign cio_gpio_o    = out_q;
  assign cio_gpio_en_o = out_en_q;
  assign intr_gpio_o   = intr_status_q & intr_en_q;

endmodule

`default_nettype wire

// File: hdl/soc_ctrl.sv
/* SoC control registers with the exit flag, exit value
   and read-only boot strap status */
`default_nettype none

module soc_ctrl (
  input  logic                       clk_i,
  input  logic                       rst_i,

  input  logic                       valid_i,
  input  logic                       write_i,
  input  ao_periph_pkg::reg_offset_t offset_i,
  input  ao_periph_pkg::strb_t       be_i,
  input  ao_periph_pkg::data_t       wdata_i,
  output ao_periph_pkg::data_t       rdata_o,

  input  logic                       boot_select_i,
  input  logic                       execute_from_flash_i,
  output logic                       exit_valid_o,
  output ao_periph_pkg::data_t       exit_value_o
);

  import ao_periph_pkg::*;

  localparam reg_offset_t EXIT_VALID_OFFSET  = 12'h000;
  localparam reg_offset_t EXIT_VALUE_OFFSET  = 12'h004;
  localparam reg_offset_t BOOT_STATUS_OFFSET = 12'h008;

  logic  wr_en;
  data_t wmask;
  logic  exit_valid_q;
  data_t exit_value_q;

  assign wr_en = valid_i & write_i;
  assign wmask = be_to_mask(be_i);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      exit_valid_q <= 1'b0;
      exit_value_q <= '0;
    end else if (wr_en) begin
      case (offset_i)
        EXIT_VALID_OFFSET: begin
          if (be_i[0]) begin
            exit_valid_q <= wdata_i[0];
          end
        end
        EXIT_VALUE_OFFSET: begin
          exit_value_q <= (exit_value_q & ~wmask) | (wdata_i & wmask);
        end
        default: ;
      endcase
    end
  end

  always_comb begin
    rdata_o = '0;
    case (offset_i)
      EXIT_VALID_OFFSET:  rdata_o[0] = exit_valid_q;
      EXIT_VALUE_OFFSET:  rdata_o = exit_value_q;
      BOOT_STATUS_OFFSET: rdata_o[1:0] = {execute_from_flash_i, boot_select_i};
      default:            rdata_o = '0;
    endcase
  end

  assign exit_valid_o = exit_valid_q;
  assign exit_value_o = exit_value_q;

endmodule

`default_nettype wire

// File: tests/ao_peripheral_subsystem_assertions.sv
/* Bus handshake and reset assertions bound to the subsystem top level */
`default_nettype none

module ao_peripheral_subsystem_assertions (
  input logic clk_i,
  input logic rst_i,
  input logic bus_req_i,
  input logic bus_gnt_o,
  input logic bus_rvalid_o,
  input logic exit_valid_o
);

  timeunit 1ns;
  timeprecision 1ps;

  logic accepted;

  assign accepted = bus_req_i & bus_gnt_o;

  // Response two edges after acceptance, and never without one
  a_rvalid_after_accept: assert property (
    @(posedge clk_i) disable iff (rst_i) accepted |-> ##2 bus_rvalid_o
  ) else $error("bus_rvalid_o missing two cycles after an accepted transfer");

  a_rvalid_needs_accept: assert property (
    @(posedge clk_i) disable iff (rst_i) bus_rvalid_o |-> $past(accepted, 2)
  ) else $error("bus_rvalid_o without an accepted transfer two cycles before");

  a_no_gnt_outstanding: assert property (
    @(posedge clk_i) disable iff (rst_i) accepted |=> !bus_gnt_o ##1 !bus_gnt_o
  ) else $error("bus_gnt_o high while a transfer is outstanding");

  a_quiet_after_reset: assert property (
    @(posedge clk_i) $fell(rst_i) |-> !bus_rvalid_o && !exit_valid_o
  ) else $error("bus_rvalid_o or exit_valid_o high right after reset");

endmodule

bind ao_peripheral_subsystem ao_peripheral_subsystem_assertions
  u_ao_peripheral_subsystem_assertions (
    .clk_i,
    .rst_i,
    .bus_req_i,
    .bus_gnt_o,
    .bus_rvalid_o,
    .exit_valid_o
  );

`default_nettype wire

// File: tests/ao_peripheral_subsystem_tb.sv
/* Directed testbench for the always-on peripheral block with
   bus driver tasks, register and pin checks, timeout and summary */
`default_nettype none

module ao_peripheral_subsystem_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import ao_periph_pkg::*;

  localparam int unsigned NUM_GPIO      = 8;
  localparam int unsigned NUM_FAST_INTR = 15;
  localparam int          MAX_CYCLES    = 2000;

  localparam data_t GPIO_MASK = 32'((33'd1 << NUM_GPIO) - 33'd1);
  localparam data_t FAST_MASK = 32'((33'd1 << NUM_FAST_INTR) - 33'd1);
  localparam data_t EXP_ERR   = 32'hBADC_AB1E;

  // Register map as seen from the bus
  localparam addr_t EXIT_VALID_ADDR   = 32'h2000_0000;
  localparam addr_t EXIT_VALUE_ADDR   = 32'h2000_0004;
  localparam addr_t BOOT_STATUS_ADDR  = 32'h2000_0008;
  localparam addr_t GPIO_IN_ADDR      = 32'h2000_1000;
  localparam addr_t GPIO_OUT_ADDR     = 32'h2000_1004;
  localparam addr_t GPIO_OUT_EN_ADDR  = 32'h2000_1008;
  localparam addr_t GPIO_INTR_EN_ADDR = 32'h2000_100C;
  localparam addr_t GPIO_STATUS_ADDR  = 32'h2000_1010;
  localparam addr_t FAST_PENDING_ADDR = 32'h2000_2000;
  localparam addr_t FAST_ENABLE_ADDR  = 32'h2000_2004;
  localparam addr_t UNMAPPED_ADDR     = 32'h2000_3000;
  localparam addr_t BAD_VALID_ADDR    = 32'h3000_0000;
  localparam addr_t BAD_VALUE_ADDR    = 32'h3000_0004;
  localparam addr_t BAD_GPIO_OUT_ADDR = 32'h3000_1004;

  logic                     clk_i;
  logic                     rst_i;
  logic                     bus_req_i;
  addr_t                    bus_addr_i;
  logic                     bus_we_i;
  strb_t                    bus_be_i;
  data_t                    bus_wdata_i;
  logic                     bus_gnt_o;
  logic                     bus_rvalid_o;
  data_t                    bus_rdata_o;
  logic                     boot_select_i;
  logic                     execute_from_flash_i;
  logic                     exit_valid_o;
  data_t                    exit_value_o;
  logic [NUM_GPIO-1:0]      cio_gpio_i;
  logic [NUM_GPIO-1:0]      cio_gpio_o;
  logic [NUM_GPIO-1:0]      cio_gpio_en_o;
  logic [NUM_GPIO-1:0]      intr_gpio_o;
  logic [NUM_FAST_INTR-1:0] fast_intr_i;
  logic [NUM_FAST_INTR-1:0] fast_intr_o;

  integer seed;
  int     errors;
  int     checks;
  int     tests_run;
  int     cycle_count = 0;
  string  test_name;

  // Expected register contents
  data_t exp_exit_value;
  data_t exp_gpio_out;
  data_t exp_gpio_out_en;
  data_t exp_fast_en;

  ao_peripheral_subsystem #(
    .NUM_GPIO      (NUM_GPIO),
    .NUM_FAST_INTR (NUM_FAST_INTR)
  ) u_ao_peripheral_subsystem (
    .clk_i                (clk_i),
    .rst_i                (rst_i),
    .bus_req_i            (bus_req_i),
    .bus_addr_i           (bus_addr_i),
    .bus_we_i             (bus_we_i),
    .bus_be_i             (bus_be_i),
    .bus_wdata_i          (bus_wdata_i),
    .bus_gnt_o            (bus_gnt_o),
    .bus_rvalid_o         (bus_rvalid_o),
    .bus_rdata_o          (bus_rdata_o),
    .boot_select_i        (boot_select_i),
    .execute_from_flash_i (execute_from_flash_i),
    .exit_valid_o         (exit_valid_o),
    .exit_value_o         (exit_value_o),
    .cio_gpio_i           (cio_gpio_i),
    .cio_gpio_o           (cio_gpio_o),
    .cio_gpio_en_o        (cio_gpio_en_o),
    .intr_gpio_o          (intr_gpio_o),
    .fast_intr_i          (fast_intr_i),
    .fast_intr_o          (fast_intr_o)
  );

  initial clk_i = 1'b0;
  always #2 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      $display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  task automatic check_data(input string what, input data_t expected, input data_t actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("CHECK FAILED: %s, %s: expected 32'h%h, actual 32'h%h",
               test_name, what, expected, actual);
    end
  endtask

  task automatic check_bits(input string what, input logic [31:0] expected,
                            input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("CHECK FAILED: %s, %s: expected %b, actual %b",
               test_name, what, expected, actual);
    end
  endtask

  function automatic data_t merge_bytes(data_t old_value, data_t new_value, strb_t be);
    data_t result;
    result = old_value;
    for (int i = 0; i < 4; i++) begin
      if (be[i]) begin
        result[8*i +: 8] = new_value[8*i +: 8];
      end
    end
    return result;
  endfunction

  task automatic next_random(output data_t value);
    value = $random(seed);
  endtask

  task automatic wait_cycles(input int count);
    repeat (count) @(negedge clk_i);
  endtask

  // Runs one transfer and returns at the falling edge where rvalid is seen
  task automatic bus_transfer(input addr_t addr, input logic we, input strb_t be,
                              input data_t wdata, output data_t rdata);
    @(negedge clk_i);
    bus_req_i   = 1'b1;
    bus_addr_i  = addr;
    bus_we_i    = we;
    bus_be_i    = be;
    bus_wdata_i = wdata;
    // Grant is combinational, so look mid cycle
    #1;
    while (!bus_gnt_o) begin
      @(negedge clk_i);
      #1;
    end
    @(negedge clk_i);
    bus_req_i = 1'b0;
    bus_we_i  = 1'b0;
    while (!bus_rvalid_o) begin
      @(negedge clk_i);
    end
    rdata = bus_rdata_o;
  endtask

  task automatic bus_write(input addr_t addr, input strb_t be, input data_t data);
    data_t rdata;
    bus_transfer(addr, 1'b1, be, data, rdata);
    check_data("write response data", 32'h0, rdata);
  endtask

  task automatic bus_read(input addr_t addr, output data_t data);
    bus_transfer(addr, 1'b0, 4'hF, 32'h0, data);
  endtask

  task automatic finish_test(input int errors_before);
    tests_run++;
    if (errors == errors_before) begin
      $display("Test %s: ok", test_name);
    end else begin
      $display("Test %s: %0d check(s) failed", test_name, errors - errors_before);
    end
  endtask

  task automatic test_reset_state();
    int errors_before;
    errors_before = errors;
    test_name = "reset_state";
    @(negedge clk_i);
    check_bits("bus_gnt_o", 32'h0, 32'(bus_gnt_o));
    check_bits("bus_rvalid_o", 32'h0, 32'(bus_rvalid_o));
    check_bits("exit_valid_o", 32'h0, 32'(exit_valid_o));
    check_data("exit_value_o", 32'h0, exit_value_o);
    check_bits("cio_gpio_o", 32'h0, 32'(cio_gpio_o));
    check_bits("cio_gpio_en_o", 32'h0, 32'(cio_gpio_en_o));
    check_bits("intr_gpio_o", 32'h0, 32'(intr_gpio_o));
    check_bits("fast_intr_o", 32'h0, 32'(fast_intr_o));
    finish_test(errors_before);
  endtask

  task automatic test_soc_ctrl();
    int    errors_before;
    data_t value;
    data_t rdata;
    errors_before = errors;
    test_name = "soc_ctrl";
    next_random(value);
    bus_write(EXIT_VALUE_ADDR, 4'hF, value);
    exp_exit_value = value;
    check_data("exit_value_o", exp_exit_value, exit_value_o);
    bus_read(EXIT_VALUE_ADDR, rdata);
    check_data("EXIT_VALUE read", exp_exit_value, rdata);
    // Bytes 0 and 2 only
    next_random(value);
    bus_write(EXIT_VALUE_ADDR, 4'b0101, value);
    exp_exit_value = merge_bytes(exp_exit_value, value, 4'b0101);
    check_data("exit_value_o after partial write", exp_exit_value, exit_value_o);
    bus_read(EXIT_VALUE_ADDR, rdata);
    check_data("EXIT_VALUE partial read", exp_exit_value, rdata);
    bus_write(EXIT_VALID_ADDR, 4'hF, 32'h1);
    check_bits("exit_valid_o", 32'h1, 32'(exit_valid_o));
    bus_read(EXIT_VALID_ADDR, rdata);
    check_data("EXIT_VALID read", 32'h1, rdata);
    boot_select_i        = 1'b1;
    execute_from_flash_i = 1'b0;
    bus_read(BOOT_STATUS_ADDR, rdata);
    check_data("BOOT_STATUS boot_select", 32'h1, rdata);
    boot_select_i        = 1'b0;
    execute_from_flash_i = 1'b1;
    bus_read(BOOT_STATUS_ADDR, rdata);
    check_data("BOOT_STATUS execute_from_flash", 32'h2, rdata);
    finish_test(errors_before);
  endtask

  task automatic test_gpio_io();
    int    errors_before;
    data_t value;
    data_t rdata;
    errors_before = errors;
    test_name = "gpio_io";
    next_random(value);
    exp_gpio_out = value & GPIO_MASK;
    bus_write(GPIO_OUT_ADDR, 4'hF, value);
    check_bits("cio_gpio_o", exp_gpio_out, 32'(cio_gpio_o));
    bus_read(GPIO_OUT_ADDR, rdata);
    check_data("OUT read", exp_gpio_out, rdata);
    next_random(value);
    exp_gpio_out_en = value & GPIO_MASK;
    bus_write(GPIO_OUT_EN_ADDR, 4'hF, value);
    check_bits("cio_gpio_en_o", exp_gpio_out_en, 32'(cio_gpio_en_o));
    bus_read(GPIO_OUT_EN_ADDR, rdata);
    check_data("OUT_EN read", exp_gpio_out_en, rdata);
    next_random(value);
    cio_gpio_i = value[NUM_GPIO-1:0];
    wait_cycles(3);
    bus_read(GPIO_IN_ADDR, rdata);
    check_data("IN read", value & GPIO_MASK, rdata);
    finish_test(errors_before);
  endtask

  task automatic test_gpio_intr();
    int    errors_before;
    data_t en;
    data_t pins;
    data_t clr;
    data_t rdata;
    errors_before = errors;
    test_name = "gpio_intr";
    @(negedge clk_i);
    cio_gpio_i = '0;
    wait_cycles(4);
    // Drop edges left over from the input test
    bus_write(GPIO_STATUS_ADDR, 4'hF, GPIO_MASK);
    bus_read(GPIO_STATUS_ADDR, rdata);
    check_data("INTR_STATUS after clear", 32'h0, rdata);
    next_random(en);
    en    = en & GPIO_MASK;
    en[0] = 1'b1;
    bus_write(GPIO_INTR_EN_ADDR, 4'hF, en);
    next_random(pins);
    pins    = pins & GPIO_MASK;
    pins[0] = 1'b1;
    @(negedge clk_i);
    cio_gpio_i = pins[NUM_GPIO-1:0];
    wait_cycles(4);
    bus_read(GPIO_STATUS_ADDR, rdata);
    check_data("INTR_STATUS after edges", pins, rdata);
    check_bits("intr_gpio_o", pins & en, 32'(intr_gpio_o));
    next_random(clr);
    clr = clr & pins;
    bus_write(GPIO_STATUS_ADDR, 4'hF, clr);
    bus_read(GPIO_STATUS_ADDR, rdata);
    check_data("INTR_STATUS after W1C", pins & ~clr, rdata);
    check_bits("intr_gpio_o after W1C", pins & ~clr & en, 32'(intr_gpio_o));
    finish_test(errors_before);
  endtask

  task automatic pulse_fast_intr(input data_t pattern);
    @(negedge clk_i);
    fast_intr_i = pattern[NUM_FAST_INTR-1:0];
    @(negedge clk_i);
    fast_intr_i = '0;
  endtask

  task automatic test_fast_intr();
    int    errors_before;
    data_t pulse;
    data_t pending;
    data_t clr;
    data_t rdata;
    errors_before = errors;
    test_name = "fast_intr";
    next_random(exp_fast_en);
    exp_fast_en = exp_fast_en & FAST_MASK;
    bus_write(FAST_ENABLE_ADDR, 4'hF, exp_fast_en);
    bus_read(FAST_ENABLE_ADDR, rdata);
    check_data("ENABLE read", exp_fast_en, rdata);
    next_random(pulse);
    pending = pulse & FAST_MASK;
    pulse_fast_intr(pulse);
    bus_read(FAST_PENDING_ADDR, rdata);
    check_data("PENDING after first pulse", pending, rdata);
    check_bits("fast_intr_o", pending & exp_fast_en, 32'(fast_intr_o));
    next_random(pulse);
    pending = pending | (pulse & FAST_MASK);
    pulse_fast_intr(pulse);
    bus_read(FAST_PENDING_ADDR, rdata);
    check_data("PENDING after second pulse", pending, rdata);
    next_random(clr);
    clr = clr & pending;
    bus_write(FAST_PENDING_ADDR, 4'hF, clr);
    pending = pending & ~clr;
    bus_read(FAST_PENDING_ADDR, rdata);
    check_data("PENDING after W1C", pending, rdata);
    check_bits("fast_intr_o after W1C", pending & exp_fast_en, 32'(fast_intr_o));
    finish_test(errors_before);
  endtask

  task automatic test_unmapped();
    int    errors_before;
    data_t junk;
    data_t rdata;
    errors_before = errors;
    test_name = "unmapped";
    bus_read(UNMAPPED_ADDR, rdata);
    check_data("read in unused window", EXP_ERR, rdata);
    bus_read(BAD_VALUE_ADDR, rdata);
    check_data("read with wrong upper bits", EXP_ERR, rdata);
    next_random(junk);
    bus_write(UNMAPPED_ADDR, 4'hF, junk);
    bus_write(UNMAPPED_ADDR + 32'h4, 4'hF, junk);
    bus_write(UNMAPPED_ADDR + 32'h8, 4'hF, ~exp_gpio_out_en);
    bus_write(BAD_VALUE_ADDR, 4'hF, ~exp_exit_value);
    bus_write(BAD_VALID_ADDR, 4'hF, 32'h0);
    bus_write(BAD_GPIO_OUT_ADDR, 4'hF, ~exp_gpio_out);
    check_bits("exit_valid_o", 32'h1, 32'(exit_valid_o));
    check_data("exit_value_o", exp_exit_value, exit_value_o);
    check_bits("cio_gpio_o", exp_gpio_out, 32'(cio_gpio_o));
    bus_read(EXIT_VALUE_ADDR, rdata);
    check_data("EXIT_VALUE unchanged", exp_exit_value, rdata);
    bus_read(GPIO_OUT_ADDR, rdata);
    check_data("OUT unchanged", exp_gpio_out, rdata);
    bus_read(GPIO_OUT_EN_ADDR, rdata);
    check_data("OUT_EN unchanged", exp_gpio_out_en, rdata);
    bus_read(FAST_ENABLE_ADDR, rdata);
    check_data("ENABLE unchanged", exp_fast_en, rdata);
    finish_test(errors_before);
  endtask

  initial begin
    seed                 = 32'hec88_1172;
    errors               = 0;
    checks               = 0;
    tests_run            = 0;
    test_name            = "none";
    exp_exit_value       = '0;
    exp_gpio_out         = '0;
    exp_gpio_out_en      = '0;
    exp_fast_en          = '0;
    rst_i                = 1'b1;
    bus_req_i            = 1'b0;
    bus_addr_i           = '0;
    bus_we_i             = 1'b0;
    bus_be_i             = '0;
    bus_wdata_i          = '0;
    boot_select_i        = 1'b0;
    execute_from_flash_i = 1'b0;
    cio_gpio_i           = '0;
    fast_intr_i          = '0;
    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;

    test_reset_state();
    test_soc_ctrl();
    test_gpio_io();
    test_gpio_intr();
    test_fast_intr();
    test_unmapped();

    $display("Summary: %0d tests, %0d checks, %0d errors", tests_run, checks, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
